// ==== filelist.f ====
hdl/vote_pkg.sv
hdl/sample_window.sv
hdl/bit_tally.sv
hdl/majority_decide.sv
hdl/recovery_stats.sv
hdl/vote_filter_top.sv
bench/tb_clock.sv
bench/tb_vote_filter.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the vote filter testbench with Verilator and runs it.
# The exit status is the simulator's own, nonzero on any failed check.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing -j 0 \
    -Wno-fatal \
    --top-module tb_vote_filter \
    -Mdir obj_dir \
    -f filelist.f

./obj_dir/Vtb_vote_filter

// ==== bench/tb_vote_filter.sv ====
// runs a fixed table then 300 LFSR samples and stops the run at the first wrong output
`timescale 1ns/1ps

module tb_vote_filter;

    localparam int          CLK_PERIOD_NS   = 40;
    localparam int          TABLE_ROWS      = 22;
    localparam int          RANDOM_COUNT    = 300;
    localparam logic [31:0] LFSR_SEED       = 32'he3cb;
    localparam int          VOTES_NEEDED    = 3;
    localparam int          LATENCY         = 4;
    localparam int          TOTAL_MAX       = (1 << vote_pkg::TOTAL_W) - 1;
    localparam int          WATCHDOG_CYCLES = TABLE_ROWS * 4 + RANDOM_COUNT * 4 + 40;

    // each row holds one nibble each for sample, idle cycles before the strobe,
    // expected voted_out and expected corr_bits
    // the first four rows only fill the window
    localparam logic [15:0] STIM_TABLE [TABLE_ROWS] = '{
        16'h0000, 16'h0000, 16'h0000, 16'h0000,
        16'h0000,
        16'hF000,  // lone glitch
        16'h0000,
        16'h0004,  // glitch sits in the centre
        16'h0300,
        16'h0000,
        16'hA100,  // step begins
        16'hA000,
        16'hA2A0,  // third A carries the vote
        16'h50A0,
        16'hA0A0,
        16'hA0A4,
        16'h30A0,
        16'h3032,
        16'h3030,
        16'hC030,
        16'h6030,
        16'h9134
    };

    logic                          clk;
    logic                          rst_n;
    logic                          valid_in;
    logic [vote_pkg::WIDTH-1:0]    sample_in;
    logic                          out_valid;
    logic [vote_pkg::WIDTH-1:0]    voted_out;
    logic [vote_pkg::CORR_W-1:0]   corr_bits;
    logic [vote_pkg::TOTAL_W-1:0]  corr_total;

    // model window with slot 0 newest
    logic [vote_pkg::WIDTH-1:0] history [5];
    int                         strobe_count;
    int                         total_exp;
    int                         cycle_cnt;
    logic [31:0]                lfsr_state;

    int exp_voted_q[$];
    int exp_corr_q[$];
    int exp_total_q[$];
    int exp_cycle_q[$];

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (16)
    ) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    vote_filter_top u_vote_filter_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .sample_in  (sample_in),
        .out_valid  (out_valid),
        .voted_out  (voted_out),
        .corr_bits  (corr_bits),
        .corr_total (corr_total)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h",
                                $time, what, got, expected));
        end
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic draw_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic int count_ones(input logic [vote_pkg::WIDTH-1:0] word);
        int n;
        n = 0;
        for (int b = 0; b < vote_pkg::WIDTH; b++) begin
            if (word[b]) n++;
        end
        return n;
    endfunction

    // per-bit vote over the model window
    function automatic logic [vote_pkg::WIDTH-1:0] model_vote();
        logic [vote_pkg::WIDTH-1:0] voted;
        int                         ones;
        voted = '0;
        for (int b = 0; b < vote_pkg::WIDTH; b++) begin
            ones = 0;
            for (int s = 0; s < 5; s++) begin
                if (history[s][b]) ones++;
            end
            voted[b] = (ones >= VOTES_NEEDED);
        end
        return voted;
    endfunction

    task automatic apply_sample(input logic [vote_pkg::WIDTH-1:0] value, input int gap,
                                input bit from_table,
                                input logic [vote_pkg::WIDTH-1:0] tbl_voted,
                                input int tbl_corr);
        logic [vote_pkg::WIDTH-1:0] voted;
        int                         corr;
        repeat (gap) begin
            @(posedge clk);
            #2;
            valid_in = 1'b0;
        end
        @(posedge clk);
        #2;
        valid_in  = 1'b1;
        sample_in = value;
        for (int s = 4; s > 0; s--) begin
            history[s] = history[s-1];
        end
        history[0] = value;
        strobe_count++;
        // warm-up strobes expect nothing
        if (strobe_count >= 5) begin
            if (from_table) begin
                voted = tbl_voted;
                corr  = tbl_corr;
            end else begin
                voted = model_vote();
                corr  = count_ones(voted ^ history[2]);
            end
            total_exp = total_exp + corr;
            if (total_exp > TOTAL_MAX) total_exp = TOTAL_MAX;
            exp_voted_q.push_back(int'(voted));
            exp_corr_q.push_back(corr);
            exp_total_q.push_back(total_exp);
            exp_cycle_q.push_back(cycle_cnt + LATENCY);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // outputs are read mid-cycle
    always @(negedge clk) begin
        if (rst_n === 1'b1 && out_valid === 1'b1) begin
            if (exp_voted_q.size() == 0) begin
                abort_run("output appeared with no sample pending");
            end else begin
                check_value("out_valid cycle", cycle_cnt, exp_cycle_q.pop_front());
                check_value("voted_out", 32'(voted_out), exp_voted_q.pop_front());
                check_value("corr_bits", 32'(corr_bits), exp_corr_q.pop_front());
                check_value("corr_total", 32'(corr_total), exp_total_q.pop_front());
            end
        end else if (exp_cycle_q.size() != 0 && cycle_cnt > exp_cycle_q[0]) begin
            abort_run("an expected output did not appear in its cycle");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        abort_run("timeout, the run took longer than the watchdog allows");
    end

    initial begin
        logic [15:0] row;
        int          rnd_value;
        int          rnd_gap;
        int          drain;
        valid_in     = 1'b0;
        sample_in    = '0;
        strobe_count = 0;
        total_exp    = 0;
        lfsr_state   = LFSR_SEED;
        for (int s = 0; s < 5; s++) begin
            history[s] = '0;
        end
        wait (rst_n === 1'b1);

        for (int i = 0; i < TABLE_ROWS; i++) begin
            row = STIM_TABLE[i];
            apply_sample(row[15:12], int'(row[11:8]), 1'b1, row[7:4], int'(row[3:0]));
        end

        // gaps of 0..3 idle cycles and enough corrections to saturate corr_total
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            draw_bits(2, rnd_gap);
            draw_bits(4, rnd_value);
            apply_sample(4'(rnd_value), rnd_gap, 1'b0, 4'h0, 0);
        end
        @(posedge clk);
        #2;
        valid_in = 1'b0;

        drain = 0;
        while (exp_cycle_q.size() != 0 && drain < 2 * LATENCY) begin
            @(posedge clk);
            drain++;
        end
        if (exp_cycle_q.size() != 0) begin
            abort_run($sformatf("%0d expected outputs are missing at the end of the run",
                                exp_cycle_q.size()));
        end else begin
            check_value("corr_total at end of run", 32'(corr_total), TOTAL_MAX);
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== bench/tb_clock.sv ====
// free-running clock from time zero, rst_n released 2 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release clear of the edge so the first strobe sees a settled reset
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== hdl/vote_filter_top.sv ====
// four-cycle latency from valid_in to out_valid, no back-pressure, one output per strobe once warm
`timescale 1ns/1ps

module vote_filter_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          valid_in,
    input  logic [vote_pkg::WIDTH-1:0]    sample_in,
    output logic                          out_valid,
    output logic [vote_pkg::WIDTH-1:0]    voted_out,
    output logic [vote_pkg::CORR_W-1:0]   corr_bits,
    output logic [vote_pkg::TOTAL_W-1:0]  corr_total
);

    // window to tally
    logic                                          win_valid;
    logic [vote_pkg::WINDOW*vote_pkg::WIDTH-1:0]   win_data;

    // tally to decide
    logic                                          tally_valid;
    logic [vote_pkg::WIDTH*vote_pkg::TALLY_W-1:0]  tally_data;
    logic [vote_pkg::WIDTH-1:0]                    center_sample;

    // decide to stats
    logic                                          vote_valid;
    logic [vote_pkg::WIDTH-1:0]                    voted_sample;
    logic [vote_pkg::WIDTH-1:0]                    corrected_mask;

    sample_window u_window (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .sample_in     (sample_in),
        .win_valid     (win_valid),
        .win_data      (win_data)
    );

    bit_tally u_tally (
        .clk           (clk),
        .rst_n         (rst_n),
        .win_valid     (win_valid),
        .win_data      (win_data),
        .tally_valid   (tally_valid),
        .tally_data    (tally_data),
        .center_sample (center_sample)
    );

    majority_decide u_decide (
        .clk            (clk),
        .rst_n          (rst_n),
        .tally_valid    (tally_valid),
        .tally_data     (tally_data),
        .center_sample  (center_sample),
        .vote_valid     (vote_valid),
        .voted_sample   (voted_sample),
        .corrected_mask (corrected_mask)
    );

    recovery_stats u_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .vote_valid     (vote_valid),
        .voted_sample   (voted_sample),
        .corrected_mask (corrected_mask),
        .out_valid      (out_valid),
        .voted_out      (voted_out),
        .corr_bits      (corr_bits),
        .corr_total     (corr_total)
    );

endmodule

// ==== hdl/recovery_stats.sv ====
// corr_total only clears on reset and sticks at all ones once it saturates
`timescale 1ns/1ps

module recovery_stats (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          vote_valid,
    input  logic [vote_pkg::WIDTH-1:0]    voted_sample,
    input  logic [vote_pkg::WIDTH-1:0]    corrected_mask,
    output logic                          out_valid,
    output logic [vote_pkg::WIDTH-1:0]    voted_out,
    output logic [vote_pkg::CORR_W-1:0]   corr_bits,
    output logic [vote_pkg::TOTAL_W-1:0]  corr_total
);

    logic [vote_pkg::CORR_W-1:0]  pop_count;
    logic [vote_pkg::TOTAL_W:0]   sum_wide;
    logic [vote_pkg::TOTAL_W-1:0] total_next;

    // popcount of the mask
    always_comb begin
        pop_count = '0;
        for (int b = 0; b < vote_pkg::WIDTH; b++) begin
            pop_count = pop_count + {{(vote_pkg::CORR_W-1){1'b0}}, corrected_mask[b]};
        end
    end

    // one extra bit catches the carry out
    assign sum_wide = {1'b0, corr_total} +
                      {{(vote_pkg::TOTAL_W+1-vote_pkg::CORR_W){1'b0}}, pop_count};

    assign total_next = sum_wide[vote_pkg::TOTAL_W] ? {vote_pkg::TOTAL_W{1'b1}}
                                                     : sum_wide[vote_pkg::TOTAL_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            voted_out  <= '0;
            corr_bits  <= '0;
            corr_total <= '0;
        end else begin
            out_valid <= vote_valid;
            if (vote_valid) begin
                voted_out  <= voted_sample;
                corr_bits  <= pop_count;
                // total already counts this sample when out_valid shows it
                corr_total <= total_next;
            end
        end
    end

endmodule

// ==== hdl/majority_decide.sv ====
// a bit votes 1 at MAJORITY ones or more, and the mask flags where the vote overrode the centre
`timescale 1ns/1ps

module majority_decide (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          tally_valid,
    input  logic [vote_pkg::WIDTH*vote_pkg::TALLY_W-1:0]  tally_data,
    input  logic [vote_pkg::WIDTH-1:0]                    center_sample,
    output logic                                          vote_valid,
    output logic [vote_pkg::WIDTH-1:0]                    voted_sample,
    output logic [vote_pkg::WIDTH-1:0]                    corrected_mask
);

    logic [vote_pkg::WIDTH-1:0] vote_next;

    always_comb begin
        for (int b = 0; b < vote_pkg::WIDTH; b++) begin
            vote_next[b] = (tally_data[b*vote_pkg::TALLY_W +: vote_pkg::TALLY_W]
                            >= vote_pkg::MAJORITY);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vote_valid <= 1'b0;
        end else begin
            vote_valid <= tally_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tally_valid) begin
            voted_sample   <= vote_next;
            // bits the vote flipped relative to the centre sample
            corrected_mask <= vote_next ^ center_sample;
        end
    end

endmodule

// ==== hdl/bit_tally.sv ====
// counts ones per bit position over all window slots and forwards the centre slot unchanged
`timescale 1ns/1ps

module bit_tally (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          win_valid,
    input  logic [vote_pkg::WINDOW*vote_pkg::WIDTH-1:0]   win_data,
    output logic                                          tally_valid,
    output logic [vote_pkg::WIDTH*vote_pkg::TALLY_W-1:0]  tally_data,
    output logic [vote_pkg::WIDTH-1:0]                    center_sample
);

    logic [vote_pkg::WIDTH*vote_pkg::TALLY_W-1:0] tally_next;

    // count for bit b sits at [b*TALLY_W +: TALLY_W]
    always_comb begin
        tally_next = '0;
        for (int b = 0; b < vote_pkg::WIDTH; b++) begin
            for (int s = 0; s < vote_pkg::WINDOW; s++) begin
                tally_next[b*vote_pkg::TALLY_W +: vote_pkg::TALLY_W] =
                    tally_next[b*vote_pkg::TALLY_W +: vote_pkg::TALLY_W] +
                    {{(vote_pkg::TALLY_W-1){1'b0}}, win_data[s*vote_pkg::WIDTH + b]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tally_valid <= 1'b0;
        end else begin
            tally_valid <= win_valid;
        end
    end

    // payload only loads with a strobe
    always_ff @(posedge clk) begin
        if (win_valid) begin
            tally_data    <= tally_next;
            center_sample <= win_data[vote_pkg::CENTER*vote_pkg::WIDTH +: vote_pkg::WIDTH];
        end
    end

endmodule

// ==== hdl/sample_window.sv ====
// slot 0 is the newest sample, idle cycles never shift, and the first four strobes give no output
`timescale 1ns/1ps

module sample_window (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         valid_in,
    input  logic [vote_pkg::WIDTH-1:0]                   sample_in,
    output logic                                         win_valid,
    output logic [vote_pkg::WINDOW*vote_pkg::WIDTH-1:0]  win_data
);

    // count of real samples held, stops at WINDOW
    logic [$clog2(vote_pkg::WINDOW+1)-1:0] fill_cnt;
    logic                                  fills_window;

    // this strobe brings the window to full, or it was full already
    assign fills_window = (fill_cnt >= vote_pkg::WINDOW - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (valid_in && (fill_cnt != vote_pkg::WINDOW)) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // shift towards the old end, new sample lands in slot 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_data <= '0;
        end else if (valid_in) begin
            win_data <= {win_data[(vote_pkg::WINDOW-1)*vote_pkg::WIDTH-1:0], sample_in};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= valid_in & fills_window;
        end
    end

endmodule

// ==== hdl/vote_pkg.sv ====
// sizes are fixed for a five-deep window of 4-bit samples and the tally logic relies on that
package vote_pkg;

    // bits per sample word
    localparam int WIDTH = 4;

    // samples that take part in each vote
    localparam int WINDOW = 5;

    // slot the vote is measured against, slot 0 being the newest
    localparam int CENTER = 2;

    // one per-bit ones count, holds 0..WINDOW
    localparam int TALLY_W = 3;

    // smallest count that votes a 1
    localparam int MAJORITY = WINDOW / 2 + 1;

    // corrected bits in one sample, holds 0..WIDTH
    localparam int CORR_W = 3;

    // running total of corrected bits, saturates at all ones
    localparam int TOTAL_W = 8;

endpackage
